//--- design/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

   // main RAM, shared by instruction and data ports
   localparam int ram_addr_w = 6;
   localparam int ram_words  = 64;

   // boot ROM, its depth is also the copy length
   localparam int rom_addr_w = 4;
   localparam int rom_words  = 16;

   // boot image lands in the top words of the RAM
   localparam int boot_base = ram_words - rom_words;

   // image file read by the ROM at elaboration
   localparam string rom_file = "boot.hex";

endpackage

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

   // word and byte strobe widths of every bus in the block
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

endpackage

`default_nettype wire

//--- design/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid/ready memory bus, word addressed
// nonzero wstrb marks a write, zero wstrb a read
interface mem_bus_if
   import mem_cfg_pkg::*, bus_pkg::*;
   ();

   logic                  valid;
   logic [ram_addr_w-1:0] addr;
   logic [data_w-1:0]     wdata;
   logic [strb_w-1:0]     wstrb;
   logic [data_w-1:0]     rdata;
   logic                  ready;

   // request side holds its request until ready
   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   // ready is a one-cycle pulse, rdata valid with it
   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );

endinterface

`default_nettype wire

//--- design/boot_seq.sv
`timescale 1ns/1ps
`default_nettype none

module boot_seq
   import mem_cfg_pkg::*, bus_pkg::*;
   (
   input  wire logic                  clk,
   input  wire logic                  rst,
   output      logic                  rom_valid,
   output      logic [rom_addr_w-1:0] rom_addr,
   input  wire logic [data_w-1:0]     rom_rdata,
   input  wire logic                  rom_ready,
   output      logic                  cnt_inc,
   input  wire logic [rom_addr_w-1:0] cnt,
   input  wire logic                  cnt_last,
   mem_bus_if.master                  copy_bus,
   output      logic                  boot_done
   );

   // read with neither flag set, write while writing, done once done_q
   logic              writing;
   logic              done_q;
   logic [data_w-1:0] word_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         writing <= 1'b0;
         done_q  <= 1'b0;
      end else if (!writing && !done_q && rom_ready) begin
         writing <= 1'b1;
      end else if (writing && copy_bus.ready) begin
         writing <= 1'b0;
         // last word written ends the copy
         done_q  <= cnt_last;
      end
   end

   // rom word held for the ram write
   always_ff @(posedge clk) begin
      if (rom_ready) begin
         word_q <= rom_rdata;
      end
   end

   assign rom_valid = !writing && !done_q;
   assign rom_addr  = cnt;

   assign copy_bus.valid = writing;
   assign copy_bus.addr  = ram_addr_w'(boot_base) + ram_addr_w'(cnt);
   assign copy_bus.wdata = word_q;
   assign copy_bus.wstrb = '1;

   assign cnt_inc   = writing && copy_bus.ready;
   assign boot_done = done_q;

   // copy write holds address and data until the ram takes it
   a_copy_hold : assert property (@(posedge clk) disable iff (rst)
      copy_bus.valid && !copy_bus.ready |=>
         copy_bus.valid && $stable(copy_bus.addr) && $stable(copy_bus.wdata));

endmodule

`default_nettype wire

//--- design/copy_counter.sv
`timescale 1ns/1ps
`default_nettype none

module copy_counter
   import mem_cfg_pkg::*;
   (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  cnt_inc,
   output      logic [rom_addr_w-1:0] cnt,
   output      logic                  cnt_last
   );

   logic copy_done;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt       <= '0;
         copy_done <= 1'b0;
      end else if (cnt_inc) begin
         // stop at the final index instead of wrapping
         if (cnt_last) begin
            copy_done <= 1'b1;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   assign cnt_last = (cnt == rom_addr_w'(rom_words - 1));

   // no further increments after the last word was counted
   a_no_extra_inc : assert property (@(posedge clk) disable iff (rst)
      copy_done |-> !cnt_inc);

endmodule

`default_nettype wire

//--- design/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom
   import mem_cfg_pkg::*, bus_pkg::*;
   (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  rom_valid,
   input  wire logic [rom_addr_w-1:0] rom_addr,
   output      logic [data_w-1:0]     rom_rdata,
   output      logic                  rom_ready
   );

   logic [data_w-1:0] rom [rom_words];

   initial begin
      $readmemh(rom_file, rom);
   end

   // one-cycle ready, no re-accept while ready is up
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rom_ready <= 1'b0;
      end else begin
         rom_ready <= rom_valid && !rom_ready;
      end
   end

   always_ff @(posedge clk) begin
      if (rom_valid && !rom_ready) begin
         rom_rdata <= rom[rom_addr];
      end
   end

endmodule

`default_nettype wire

//--- design/bus_merge.sv
`timescale 1ns/1ps
`default_nettype none

// hi always wins, lo waits while hi is valid
module bus_merge (
   mem_bus_if.slave  hi,
   mem_bus_if.slave  lo,
   mem_bus_if.master out
   );

   logic sel_hi;

   assign sel_hi = hi.valid;

   // request path
   assign out.valid = hi.valid || lo.valid;
   assign out.addr  = sel_hi ? hi.addr  : lo.addr;
   assign out.wdata = sel_hi ? hi.wdata : lo.wdata;
   assign out.wstrb = sel_hi ? hi.wstrb : lo.wstrb;

   // response goes back to the granted master only
   assign hi.ready = sel_hi && out.ready;
   assign lo.ready = !sel_hi && out.ready;
   assign hi.rdata = sel_hi ? out.rdata : '0;
   assign lo.rdata = sel_hi ? '0 : out.rdata;

endmodule

`default_nettype wire

//--- design/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram
   import mem_cfg_pkg::*, bus_pkg::*;
   (
   input wire logic clk,
   input wire logic rst,
   mem_bus_if.slave ip,
   mem_bus_if.slave dp
   );

   logic [data_w-1:0] mem [ram_words];
   logic              ip_acc;
   logic              dp_acc;

   // a held valid is taken again only after its ready pulse
   assign ip_acc = ip.valid && !ip.ready;
   assign dp_acc = dp.valid && !dp.ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ip.ready <= 1'b0;
         dp.ready <= 1'b0;
      end else begin
         ip.ready <= ip_acc;
         dp.ready <= dp_acc;
      end
   end

   // data port writes come second so they win a collision
   always_ff @(posedge clk) begin
      for (int b = 0; b < strb_w; b++) begin
         if (ip_acc && ip.wstrb[b]) begin
            mem[ip.addr][8*b +: 8] <= ip.wdata[8*b +: 8];
         end
         if (dp_acc && dp.wstrb[b]) begin
            mem[dp.addr][8*b +: 8] <= dp.wdata[8*b +: 8];
         end
      end
   end

   // registered reads, old word on read during write
   always_ff @(posedge clk) begin
      if (ip_acc) begin
         ip.rdata <= mem[ip.addr];
      end
      if (dp_acc) begin
         dp.rdata <= mem[dp.addr];
      end
   end

endmodule

`default_nettype wire

//--- design/int_mem.sv
`timescale 1ns/1ps
`default_nettype none

module int_mem
   import mem_cfg_pkg::*, bus_pkg::*;
   (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  i_valid,
   input  wire logic [ram_addr_w-1:0] i_addr,
   output      logic [data_w-1:0]     i_rdata,
   output      logic                  i_ready,
   input  wire logic                  d_valid,
   input  wire logic [ram_addr_w-1:0] d_addr,
   input  wire logic [data_w-1:0]     d_wdata,
   input  wire logic [strb_w-1:0]     d_wstrb,
   output      logic [data_w-1:0]     d_rdata,
   output      logic                  d_ready,
   output      logic                  boot_done
   );

   mem_bus_if copy_bus ();
   mem_bus_if ibus_in ();
   mem_bus_if ram_i ();
   mem_bus_if ram_d ();

   logic                  rom_valid;
   logic [rom_addr_w-1:0] rom_addr;
   logic [data_w-1:0]     rom_rdata;
   logic                  rom_ready;
   logic                  cnt_inc;
   logic [rom_addr_w-1:0] cnt;
   logic                  cnt_last;

   // instruction side is read only and held off until boot is done
   assign ibus_in.valid = i_valid && boot_done;
   assign ibus_in.addr  = i_addr;
   assign ibus_in.wdata = '0;
   assign ibus_in.wstrb = '0;
   assign i_rdata       = ibus_in.rdata;
   assign i_ready       = ibus_in.ready;

   assign ram_d.valid = d_valid;
   assign ram_d.addr  = d_addr;
   assign ram_d.wdata = d_wdata;
   assign ram_d.wstrb = d_wstrb;
   assign d_rdata     = ram_d.rdata;
   assign d_ready     = ram_d.ready;

   boot_seq u_boot_seq (
      .clk(clk), .rst(rst),
      .rom_valid(rom_valid), .rom_addr(rom_addr),
      .rom_rdata(rom_rdata), .rom_ready(rom_ready),
      .cnt_inc(cnt_inc), .cnt(cnt), .cnt_last(cnt_last),
      .copy_bus(copy_bus.master), .boot_done(boot_done)
   );

   copy_counter u_copy_counter (
      .clk(clk), .rst(rst), .cnt_inc(cnt_inc), .cnt(cnt), .cnt_last(cnt_last)
   );

   boot_rom u_boot_rom (
      .clk(clk), .rst(rst), .rom_valid(rom_valid), .rom_addr(rom_addr),
      .rom_rdata(rom_rdata), .rom_ready(rom_ready)
   );

   // copy traffic in slot 1 ahead of instruction fetches
   bus_merge u_bus_merge (
      .hi(copy_bus.slave), .lo(ibus_in.slave), .out(ram_i.master)
   );

   dual_port_ram u_ram (
      .clk(clk), .rst(rst), .ip(ram_i.slave), .dp(ram_d.slave)
   );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int period     = 40,
   parameter int rst_cycles = 4
   ) (
   output logic clk,
   output logic rst
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // release lands after the flops have sampled this edge
   initial begin
      rst = 1'b1;
      repeat (rst_cycles) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

//--- tb/int_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_mem_tb
   import mem_cfg_pkg::*, bus_pkg::*;
   ();

   localparam int n_writes    = 200;
   localparam int n_share     = 20;
   localparam int n_bg        = 3;
   localparam int n_xfers     = 1 + rom_words + 2 * n_writes + n_share * (2 + n_bg);
   localparam int cycle_limit = 4 * rom_words + 8 * n_xfers + 100;

   logic                  clk;
   logic                  rst;
   logic                  i_valid;
   logic [ram_addr_w-1:0] i_addr;
   logic [data_w-1:0]     i_rdata;
   logic                  i_ready;
   logic                  d_valid;
   logic [ram_addr_w-1:0] d_addr;
   logic [data_w-1:0]     d_wdata;
   logic [strb_w-1:0]     d_wstrb;
   logic [data_w-1:0]     d_rdata;
   logic                  d_ready;
   logic                  boot_done;

   // reference memory, plus which bytes of it hold defined values
   logic [data_w-1:0] model [ram_words];
   logic [strb_w-1:0] known [ram_words];
   int errors = 0;
   int checks = 0;
   int cycles = 0;

   tb_clk_gen #(.period(40), .rst_cycles(4)) u_clk_gen (.clk(clk), .rst(rst));

   int_mem u_int_mem (
      .clk(clk), .rst(rst),
      .i_valid(i_valid), .i_addr(i_addr), .i_rdata(i_rdata), .i_ready(i_ready),
      .d_valid(d_valid), .d_addr(d_addr), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
      .d_rdata(d_rdata), .d_ready(d_ready), .boot_done(boot_done)
   );

   task automatic report_mismatch(input string name, input logic [data_w-1:0] exp, got);
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, got);
   endtask

   task automatic end_test(input string name, input int start);
      $display("test %s finished with %0d errors", name, errors - start);
   endtask

   task automatic check_idle();
      checks++;
      if ({i_ready, d_ready, boot_done} !== 3'b000) begin
         report_mismatch("reset_state", '0, data_w'({i_ready, d_ready, boot_done}));
      end
   endtask

   // random word address, skipping one address and optionally undefined words
   function automatic logic [ram_addr_w-1:0] pick_addr(input bit defined, input int skip);
      logic [ram_addr_w-1:0] a;
      do
         a = ram_addr_w'($urandom_range(ram_words - 1, 0));
      while ((defined && known[a] != '1) || int'(a) == skip);
      return a;
   endfunction

   function automatic logic [strb_w-1:0] rand_strb();
      return strb_w'($urandom_range((1 << strb_w) - 1, 1));
   endfunction

   task automatic instr_read(input logic [ram_addr_w-1:0] addr, input string name);
      @(posedge clk);
      i_valid <= 1'b1;
      i_addr  <= addr;
      do
         @(posedge clk);
      while (!i_ready);
      i_valid <= 1'b0;
      checks++;
      if (!boot_done) begin
         errors++;
         $display("%s: instruction read completed before boot_done", name);
      end
      checks++;
      if (i_rdata !== model[addr]) begin
         report_mismatch(name, model[addr], i_rdata);
      end
   endtask

   task automatic data_write(input logic [ram_addr_w-1:0] addr,
                             input logic [data_w-1:0] data,
                             input logic [strb_w-1:0] strb);
      @(posedge clk);
      d_valid <= 1'b1;
      d_addr  <= addr;
      d_wdata <= data;
      d_wstrb <= strb;
      do
         @(posedge clk);
      while (!d_ready);
      d_valid <= 1'b0;
      // only strobed bytes change
      for (int b = 0; b < strb_w; b++) begin
         if (strb[b]) begin
            model[addr][8*b +: 8] = data[8*b +: 8];
            known[addr][b] = 1'b1;
         end
      end
   endtask

   task automatic data_read(input logic [ram_addr_w-1:0] addr, input string name);
      @(posedge clk);
      d_valid <= 1'b1;
      d_addr  <= addr;
      d_wstrb <= '0;
      do
         @(posedge clk);
      while (!d_ready);
      d_valid <= 1'b0;
      checks++;
      if (d_rdata !== model[addr]) begin
         report_mismatch(name, model[addr], d_rdata);
      end
   endtask

   // data port traffic that never touches the word under test
   task automatic background_traffic(input int skip);
      repeat (n_bg) begin
         if ($urandom_range(1, 0) == 1) begin
            data_write(pick_addr(1'b0, skip), $urandom, rand_strb());
         end else begin
            data_read(pick_addr(1'b1, skip), "shared_memory");
         end
      end
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      int start;
      int order [rom_words];
      int j;
      int tmp;
      logic [ram_addr_w-1:0] addr;

      void'($urandom(2277));
      i_valid = 1'b0;
      i_addr  = '0;
      d_valid = 1'b0;
      d_addr  = '0;
      d_wdata = '0;
      d_wstrb = '0;
      for (int a = 0; a < ram_words; a++) begin
         known[a] = (a >= boot_base) ? '1 : '0;
      end
      $readmemh("boot.hex", model, boot_base, ram_words - 1);

      start = errors;
      do begin
         @(posedge clk);
         check_idle();
      end while (rst);
      @(posedge clk);
      check_idle();
      end_test("reset_state", start);

      // issued while the copy still runs
      start = errors;
      instr_read(ram_addr_w'(boot_base + $urandom_range(rom_words - 1, 0)), "boot_stall");
      end_test("boot_stall", start);

      start = errors;
      for (int k = 0; k < rom_words; k++) begin
         order[k] = k;
      end
      for (int k = rom_words - 1; k > 0; k--) begin
         j = $urandom_range(k, 0);
         tmp = order[k];
         order[k] = order[j];
         order[j] = tmp;
      end
      for (int k = 0; k < rom_words; k++) begin
         instr_read(ram_addr_w'(boot_base + order[k]), "boot_image");
      end
      end_test("boot_image", start);

      start = errors;
      for (int n = 0; n < n_writes; n++) begin
         data_write(pick_addr(1'b0, -1), $urandom, rand_strb());
         if ($urandom_range(1, 0) == 1) begin
            data_read(pick_addr(1'b1, -1), "data_path");
         end
      end
      end_test("data_path", start);

      start = errors;
      for (int n = 0; n < n_share; n++) begin
         addr = pick_addr(1'b0, -1);
         data_write(addr, $urandom, '1);
         fork
            instr_read(addr, "shared_memory");
            background_traffic(int'(addr));
         join
      end
      end_test("shared_memory", start);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- boot.hex
// one 32-bit hex word per line, boot ROM words 0 to 15
00000093
00100113
00200193
10000237
00020213
00022283
00128293
00522023
00410113
fe311ce3
00000317
01c30313
00032383
00738433
0000006f
00000013

//--- Makefile
TOP := int_mem_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, fail unless the log reports a pass"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
design/mem_cfg_pkg.sv
design/bus_pkg.sv
design/mem_bus_if.sv
design/boot_seq.sv
design/copy_counter.sv
design/boot_rom.sv
design/bus_merge.sv
design/dual_port_ram.sv
design/int_mem.sv
tb/tb_clk_gen.sv
tb/int_mem_tb.sv
